//--- sim.f
+incdir+design
design/dcache_pkg.sv
design/dcache_lookup.sv
design/dcache_store.sv
design/dcache_miss_ctrl.sv
design/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - design
    files:
      - design/dcache_pkg.sv
      - design/dcache_lookup.sv
      - design/dcache_store.sv
      - design/dcache_miss_ctrl.sv
      - design/dcache_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - test/dcache_mem_model.sv
      - test/dcache_tb.sv

//--- test/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int    clk_period   = 100;
    localparam word_t fill_pattern = 32'h5a3c_96e1;
    localparam int    max_mem_wait = 6;                     // cycles per memory transfer
    localparam int    worst_cycles = 2 * max_mem_wait + 4;  // write back, refill, hit
    localparam int    n_random     = 40;
    localparam int    n_requests   = 2 + 19 + 9 + 3 + n_random;
    localparam int    watchdog_ns  = (n_requests * (worst_cycles + 3) + 20) * clk_period;

    logic     clk;
    logic     rst;
    logic     p_strobe;
    logic     p_rw;
    addr_t    p_a;
    byte_en_t p_wen;
    word_t    p_dout;
    word_t    p_din;
    logic     p_ready;
    logic     m_strobe;
    logic     m_rw;
    addr_t    m_a;
    byte_en_t m_wen;
    word_t    m_din;
    logic     m_ready;
    word_t    m_dout;
    logic     req_uncached;

    int    errors;
    int    errors_at_start;
    int    requests;
    int    strobe_cycles;
    logic  log_rw [$];   // completed memory transfers, oldest first
    addr_t log_a  [$];
    word_t log_d  [$];
    word_t expect_mem [addr_t];

    dcache_top UUT (
        .clk(clk), .rst(rst),
        .p_strobe(p_strobe), .p_rw(p_rw), .p_a(p_a), .p_wen(p_wen), .p_dout(p_dout),
        .p_din(p_din), .p_ready(p_ready),
        .m_strobe(m_strobe), .m_rw(m_rw), .m_a(m_a), .m_wen(m_wen), .m_din(m_din),
        .m_ready(m_ready), .m_dout(m_dout)
    );

    dcache_mem_model #(.fill_pattern(fill_pattern)) mem_model (
        .clk(clk), .rst(rst),
        .m_strobe(m_strobe), .m_rw(m_rw), .m_a(m_a), .m_wen(m_wen), .m_din(m_din),
        .m_ready(m_ready), .m_dout(m_dout)
    );

    assign req_uncached = (p_a[`DC_ADDR_W-1 -: `DC_UNCACHED_W] == `DC_UNCACHED_CODE);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before all tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    always @(posedge clk) begin
        if (!rst && m_strobe) begin
            strobe_cycles++;
            if (m_ready) begin
                log_rw.push_back(m_rw);
                log_a.push_back(m_a);
                log_d.push_back(m_rw ? m_din : m_dout);
            end
        end
    end

    ////////////////////////////////////////
    // protocol properties
    ////////////////////////////////////////
    assert property (@(posedge clk) disable iff (rst) !p_strobe |-> !m_strobe && !p_ready)
        else begin
            errors++;
            $display("memory strobe or p_ready high with no request pending");
        end

    assert property (@(posedge clk) disable iff (rst) m_strobe && !m_ready |=> $stable(m_a))
        else begin
            errors++;
            $display("FAILED m_a changed to 0x%08h before m_ready", m_a);
        end

    assert property (@(posedge clk) disable iff (rst)
        m_strobe && !m_ready |=> m_strobe && $stable(m_rw) && $stable(m_din) && $stable(m_wen))
        else begin
            errors++;
            $display("memory request dropped or changed before m_ready");
        end

    assert property (@(posedge clk) disable iff (rst) m_strobe && !m_rw |-> m_a == p_a)
        else begin
            errors++;
            $display("FAILED m_a got 0x%08h expected 0x%08h", m_a, p_a);
        end

    // uncached window passes straight through
    assert property (@(posedge clk) disable iff (rst) p_strobe && req_uncached |->
        m_strobe && m_a == p_a && m_rw == p_rw && m_wen == p_wen && m_din == p_dout)
        else begin
            errors++;
            $display("bypass request not copied to the memory port, m_a 0x%08h", m_a);
        end

    assert property (@(posedge clk) disable iff (rst) p_strobe && req_uncached |->
        p_din == m_dout && p_ready == m_ready)
        else begin
            errors++;
            $display("FAILED p_din got 0x%08h expected 0x%08h", p_din, m_dout);
        end

    assert property (@(posedge clk) disable iff (rst) p_ready |=> !p_ready)
        else begin
            errors++;
            $display("p_ready stayed high for more than one cycle");
        end

    ////////////////////////////////////////
    // reference model and request tasks
    ////////////////////////////////////////
    function automatic word_t expected_word(input addr_t a);
        if (expect_mem.exists(a)) begin
            return expect_mem[a];
        end
        return a ^ fill_pattern;
    endfunction

    function automatic logic mask_allowed(input byte_en_t wen);
        return wen inside {4'b1111, 4'b1100, 4'b0011, 4'b1000, 4'b0100, 4'b0010, 4'b0001};
    endfunction

    function automatic addr_t line_addr(input int tag, input int set);
        return (addr_t'(tag) << (`DC_SET_BITS + `DC_OFFSET_BITS))
             | (addr_t'(set) << `DC_OFFSET_BITS);
    endfunction

    task automatic access(input addr_t a, input logic rw, input byte_en_t wen,
                          input word_t wd, output word_t rd, output int cycles);
        @(negedge clk);
        p_strobe = 1'b1;
        p_rw     = rw;
        p_a      = a;
        p_wen    = wen;
        p_dout   = wd;
        cycles   = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (p_ready !== 1'b1 && cycles < worst_cycles);
        rd = p_din;
        if (p_ready !== 1'b1) begin
            errors++;
            $display("request at 0x%08h never got p_ready", a);
        end
        requests++;
        @(negedge clk);
        p_strobe = 1'b0;   // one idle cycle between requests
    endtask

    task automatic read_check(input addr_t a, output int cycles);
        word_t rd;
        word_t exp;
        exp = expected_word(a);
        access(a, 1'b0, 4'hf, '0, rd, cycles);
        assert (rd === exp)
            else begin
                errors++;
                $display("FAILED p_din at 0x%08h got 0x%08h expected 0x%08h", a, rd, exp);
            end
    endtask

    task automatic write_word(input addr_t a, input byte_en_t wen, input word_t d);
        word_t rd;
        word_t cur;
        int    cycles;
        access(a, 1'b1, wen, d, rd, cycles);
        cur = expected_word(a);
        if (mask_allowed(wen)) begin
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) begin
                    cur[8*b +: 8] = d[8*b +: 8];
                end
            end
        end
        expect_mem[a] = cur;
    endtask

    task automatic clear_log();
        log_rw.delete();
        log_a.delete();
        log_d.delete();
    endtask

    task automatic end_test(input string name);
        $display("test %-10s finished with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        int       cycles;
        int       strobes_before;
        addr_t    a;
        addr_t    lines [5];
        byte_en_t masks [9];
        word_t    evicted;
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_a      = '0;
        p_wen    = '0;
        p_dout   = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        repeat (4) @(negedge clk);
        assert (!m_strobe && !p_ready)
            else begin
                errors++;
                $display("memory port or processor port active after reset");
            end
        end_test("reset");

        a = line_addr(3, 7'h05);
        clear_log();
        read_check(a, cycles);
        assert (cycles > 1 && log_a.size() == 1 && log_rw[0] == 1'b0 && log_a[0] == a)
            else begin
                errors++;
                $display("read miss did not make exactly one memory read at 0x%08h", a);
            end
        strobes_before = strobe_cycles;
        read_check(a, cycles);
        assert (cycles == 1 && strobe_cycles == strobes_before)
            else begin
                errors++;
                $display("second read of 0x%08h was not a one-cycle hit", a);
            end
        end_test("miss_hit");

        // last two masks are outside the allowed set
        masks = '{4'b1111, 4'b1100, 4'b0011, 4'b1000, 4'b0100,
                  4'b0010, 4'b0001, 4'b0101, 4'b1110};
        a = line_addr(9, 7'h10);
        read_check(a, cycles);
        for (int i = 0; i < 9; i++) begin
            write_word(a, masks[i], 32'hc0de_0000 ^ (i * 32'h1357_9bdf));
            read_check(a, cycles);
        end
        end_test("byte_store");

        for (int t = 0; t < 5; t++) begin
            lines[t] = line_addr(16 + t, 7'h20);
        end
        for (int t = 0; t < 4; t++) begin
            write_word(lines[t], 4'hf, 32'h4000_0000 + t * 32'h0101);
        end
        read_check(lines[0], cycles);
        read_check(lines[2], cycles);
        read_check(lines[3], cycles);   // lines[1] is now least recently used
        evicted = expected_word(lines[1]);
        clear_log();
        read_check(lines[4], cycles);
        assert (log_a.size() == 2 && log_rw[0] == 1'b1 && log_rw[1] == 1'b0)
            else begin
                errors++;
                $display("fifth tag did not cause one write back followed by one read");
            end
        if (log_a.size() == 2) begin
            assert (log_a[0] == lines[1])
                else begin
                    errors++;
                    $display("FAILED m_a got 0x%08h expected 0x%08h", log_a[0], lines[1]);
                end
            assert (log_d[0] == evicted)
                else begin
                    errors++;
                    $display("FAILED m_din got 0x%08h expected 0x%08h", log_d[0], evicted);
                end
            assert (log_a[1] == lines[4])
                else begin
                    errors++;
                    $display("FAILED m_a got 0x%08h expected 0x%08h", log_a[1], lines[4]);
                end
        end
        read_check(lines[1], cycles);
        end_test("lru_evict");

        a = 32'ha000_0040;
        write_word(a, 4'hf, 32'h0bad_cafe);
        clear_log();
        read_check(a, cycles);
        read_check(a, cycles);
        assert (log_a.size() == 2)
            else begin
                errors++;
                $display("repeated bypass read was served without memory");
            end
        end_test("bypass");

        // few sets, seven tags each, so dirty evictions keep happening
        for (int i = 0; i < n_random; i++) begin
            a = line_addr(32 + (i * 5) % 7, 7'h40 + i % 3);
            if (i % 8 == 5) begin
                a = 32'ha000_1000 + i * 4;
            end
            if (i % 3 == 1) begin
                write_word(a, 4'hf, 32'h6000_0000 ^ (i * 32'h0f1e_2d3c));
            end else begin
                read_check(a, cycles);
            end
        end
        end_test("mem_delay");

        $display("requests %0d, errors %0d", requests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- test/dcache_mem_model.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_mem_model #(
    parameter dcache_pkg::word_t fill_pattern = 32'h5a3c_96e1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 m_strobe,
    input  logic                 m_rw,
    input  dcache_pkg::addr_t    m_a,
    input  dcache_pkg::byte_en_t m_wen,
    input  dcache_pkg::word_t    m_din,
    output logic                 m_ready,
    output dcache_pkg::word_t    m_dout
);
    import dcache_pkg::*;

    word_t       mem [addr_t];   // sparse, holds written words only
    logic        ready_q = 1'b0;
    word_t       dout_q  = '0;
    logic        busy    = 1'b0;
    logic        go      = 1'b0;  // answer on the next falling edge
    int          wait_left;
    logic [31:0] lfsr;
    addr_t       req_a;
    logic        req_rw;
    byte_en_t    req_wen;
    word_t       req_din;

    assign m_ready = ready_q;
    assign m_dout  = dout_q;

    // fibonacci form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t stored_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ fill_pattern;   // untouched words follow the address
    endfunction

    ////////////////////////////////////////
    // request capture and delay count
    ////////////////////////////////////////
    always @(posedge clk) begin : request_side
        logic [31:0] s;
        logic [1:0]  bits;
        word_t       w;
        if (rst) begin
            busy <= 1'b0;
            go   <= 1'b0;
            lfsr <= 32'd71520;
        end else if (ready_q) begin
            if (req_rw) begin
                w = stored_word(req_a);
                for (int b = 0; b < 4; b++) begin
                    if (req_wen[b]) begin
                        w[8*b +: 8] = req_din[8*b +: 8];
                    end
                end
                mem[req_a] = w;
            end
            busy <= 1'b0;
            go   <= 1'b0;
        end else if (busy) begin
            if (wait_left == 0) begin
                go <= 1'b1;
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (m_strobe) begin
            s       = lfsr_step(lfsr);   // one step per bit taken
            bits[0] = s[0];
            s       = lfsr_step(s);
            bits[1] = s[0];
            lfsr      <= s;
            wait_left <= int'(bits);
            busy      <= 1'b1;
            req_a     <= m_a;
            req_rw    <= m_rw;
            req_wen   <= m_wen;
            req_din   <= m_din;
        end
    end

    // answer side, changes on the falling edge like the processor inputs
    always @(negedge clk) begin
        ready_q <= go && !rst;
        if (go && !req_rw) begin
            dout_q <= stored_word(req_a);
        end
    end

endmodule

//--- design/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    // processor port
    input  logic                 p_strobe,
    input  logic                 p_rw,
    input  dcache_pkg::addr_t    p_a,
    input  dcache_pkg::byte_en_t p_wen,
    input  dcache_pkg::word_t    p_dout,
    output dcache_pkg::word_t    p_din,
    output logic                 p_ready,
    // memory port
    output logic                 m_strobe,
    output logic                 m_rw,
    output dcache_pkg::addr_t    m_a,
    output dcache_pkg::byte_en_t m_wen,
    output dcache_pkg::word_t    m_din,
    input  logic                 m_ready,
    input  dcache_pkg::word_t    m_dout
);
    import dcache_pkg::*;

    // addressed set, store to lookup
    logic [`DC_WAYS-1:0] way_valid;
    logic [`DC_WAYS-1:0] way_dirty;
    tag_t                way_tag  [`DC_WAYS];
    age_t                way_age  [`DC_WAYS];
    word_t               way_data [`DC_WAYS];

    // lookup results
    index_t index;
    logic   hit;
    way_t   hit_way;
    word_t  hit_data;
    logic   bypass;
    way_t   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;
    word_t  victim_data;

    // refill path
    logic  fill_en;
    word_t fill_data;

    dcache_lookup u_lookup (
        .p_a(p_a), .p_strobe(p_strobe),
        .way_valid(way_valid), .way_dirty(way_dirty),
        .way_tag(way_tag), .way_age(way_age), .way_data(way_data),
        .index(index), .hit(hit), .hit_way(hit_way), .hit_data(hit_data),
        .bypass(bypass), .victim_way(victim_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_data(victim_data)
    );

    dcache_store u_store (
        .clk(clk), .rst(rst),
        .index(index), .tag(p_a[`DC_ADDR_W-1 -: `DC_TAG_W]),
        .hit(hit), .hit_way(hit_way),
        .p_rw(p_rw), .p_wen(p_wen), .p_dout(p_dout),
        .fill_en(fill_en), .victim_way(victim_way), .fill_data(fill_data),
        .way_valid(way_valid), .way_dirty(way_dirty),
        .way_tag(way_tag), .way_age(way_age), .way_data(way_data)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk(clk), .rst(rst),
        .p_strobe(p_strobe), .p_rw(p_rw), .p_a(p_a), .p_wen(p_wen), .p_dout(p_dout),
        .hit(hit), .bypass(bypass), .victim_dirty(victim_dirty), .index(index),
        .victim_tag(victim_tag), .victim_data(victim_data), .hit_data(hit_data),
        .m_ready(m_ready), .m_dout(m_dout),
        .m_strobe(m_strobe), .m_rw(m_rw), .m_a(m_a), .m_wen(m_wen), .m_din(m_din),
        .p_din(p_din), .p_ready(p_ready),
        .fill_en(fill_en), .fill_data(fill_data)
    );

endmodule

//--- design/dcache_miss_ctrl.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_miss_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 p_strobe,
    input  logic                 p_rw,
    input  dcache_pkg::addr_t    p_a,
    input  dcache_pkg::byte_en_t p_wen,
    input  dcache_pkg::word_t    p_dout,
    input  logic                 hit,
    input  logic                 bypass,
    input  logic                 victim_dirty,
    input  dcache_pkg::index_t   index,
    input  dcache_pkg::tag_t     victim_tag,
    input  dcache_pkg::word_t    victim_data,
    input  dcache_pkg::word_t    hit_data,
    input  logic                 m_ready,
    input  dcache_pkg::word_t    m_dout,
    output logic                 m_strobe,
    output logic                 m_rw,
    output dcache_pkg::addr_t    m_a,
    output dcache_pkg::byte_en_t m_wen,
    output dcache_pkg::word_t    m_din,
    output dcache_pkg::word_t    p_din,
    output logic                 p_ready,
    output logic                 fill_en,
    output dcache_pkg::word_t    fill_data
);
    import dcache_pkg::*;

    miss_state_t state;
    miss_state_t state_next;
    logic        cached_miss;

    assign cached_miss = p_strobe && !bypass && !hit;

    ////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ms_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ms_idle: begin
                if (cached_miss) begin
                    state_next = victim_dirty ? ms_write_back : ms_refill;
                end
            end
            ms_write_back: if (m_ready) state_next = ms_refill;
            ms_refill:     if (m_ready) state_next = ms_idle;   // request hits next cycle
            default:       state_next = ms_idle;
        endcase
    end

    // memory port, fields held for the whole state
    always_comb begin
        case (state)
            ms_write_back: begin
                m_strobe = 1'b1;
                m_rw     = 1'b1;
                m_a      = {victim_tag, index, {`DC_OFFSET_BITS{1'b0}}};
                m_wen    = '1;
                m_din    = victim_data;
            end
            ms_refill: begin
                m_strobe = 1'b1;
                m_rw     = 1'b0;
                m_a      = p_a;
                m_wen    = '1;
                m_din    = '0;
            end
            default: begin   // idle passes uncached traffic through
                m_strobe = p_strobe && bypass;
                m_rw     = p_rw;
                m_a      = p_a;
                m_wen    = p_wen;
                m_din    = p_dout;
            end
        endcase
    end

    assign fill_en   = (state == ms_refill) && m_ready;
    assign fill_data = m_dout;

    // processor return path
    assign p_ready = bypass ? (p_strobe && m_ready) : hit;
    assign p_din   = bypass ? m_dout : hit_data;

endmodule

//--- design/dcache_store.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_store (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::index_t   index,
    input  dcache_pkg::tag_t     tag,
    input  logic                 hit,
    input  dcache_pkg::way_t     hit_way,
    input  logic                 p_rw,
    input  dcache_pkg::byte_en_t p_wen,
    input  dcache_pkg::word_t    p_dout,
    input  logic                 fill_en,
    input  dcache_pkg::way_t     victim_way,
    input  dcache_pkg::word_t    fill_data,
    output logic [`DC_WAYS-1:0]  way_valid,
    output logic [`DC_WAYS-1:0]  way_dirty,
    output dcache_pkg::tag_t     way_tag  [`DC_WAYS],
    output dcache_pkg::age_t     way_age  [`DC_WAYS],
    output dcache_pkg::word_t    way_data [`DC_WAYS]
);
    import dcache_pkg::*;

    // per-set state, one entry per way
    logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty_q [`DC_SETS];
    tag_t                tag_q   [`DC_SETS][`DC_WAYS];
    age_t                age_q   [`DC_SETS][`DC_WAYS];
    word_t               data_q  [`DC_SETS][`DC_WAYS];

    logic store_hit;
    logic mask_ok;
    logic touch;
    way_t touch_way;

    assign store_hit = hit && p_rw;
    assign touch     = hit || fill_en;
    assign touch_way = fill_en ? victim_way : hit_way;

    // byte masks the store path accepts
    always_comb begin
        case (p_wen)
            4'b1111, 4'b1100, 4'b0011,
            4'b1000, 4'b0100, 4'b0010, 4'b0001: mask_ok = 1'b1;
            default:                            mask_ok = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // line status
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_en) begin
            valid_q[index][victim_way] <= 1'b1;
            dirty_q[index][victim_way] <= 1'b0;   // fresh copy of memory
        end else if (store_hit) begin
            dirty_q[index][hit_way] <= 1'b1;      // set even for an odd mask
        end
    end

    // tag and data
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[index][victim_way]  <= tag;
            data_q[index][victim_way] <= fill_data;
        end else if (store_hit && mask_ok) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (p_wen[b]) begin
                    data_q[index][hit_way][8*b +: 8] <= p_dout[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // LRU ages
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (touch) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (way_t'(w) == touch_way) begin
                    age_q[index][w] <= '0;
                end else if (age_q[index][w] != '1) begin
                    age_q[index][w] <= age_q[index][w] + 1'b1;   // saturate at max
                end
            end
        end
    end

    // combinational read of the addressed set
    assign way_valid = valid_q[index];
    assign way_dirty = dirty_q[index];

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_tag[w]  = tag_q[index][w];
            way_age[w]  = age_q[index][w];
            way_data[w] = data_q[index][w];
        end
    end

endmodule

//--- design/dcache_lookup.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_lookup (
    input  dcache_pkg::addr_t   p_a,
    input  logic                p_strobe,
    input  logic [`DC_WAYS-1:0] way_valid,
    input  logic [`DC_WAYS-1:0] way_dirty,
    input  dcache_pkg::tag_t    way_tag  [`DC_WAYS],
    input  dcache_pkg::age_t    way_age  [`DC_WAYS],
    input  dcache_pkg::word_t   way_data [`DC_WAYS],
    output dcache_pkg::index_t  index,
    output logic                hit,
    output dcache_pkg::way_t    hit_way,
    output dcache_pkg::word_t   hit_data,
    output logic                bypass,
    output dcache_pkg::way_t    victim_way,
    output logic                victim_dirty,
    output dcache_pkg::tag_t    victim_tag,
    output dcache_pkg::word_t   victim_data
);
    import dcache_pkg::*;

    tag_t                req_tag;
    logic [`DC_WAYS-1:0] match;
    logic                any_invalid;
    way_t                invalid_way;
    way_t                oldest_way;
    age_t                oldest_age;

    // address split
    assign index   = p_a[`DC_OFFSET_BITS +: `DC_SET_BITS];
    assign req_tag = p_a[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign bypass  = (p_a[`DC_ADDR_W-1 -: `DC_UNCACHED_W] == `DC_UNCACHED_CODE);

    ////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = way_valid[w] && (way_tag[w] == req_tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = `DC_WAYS-1; w >= 0; w--) begin   // downward so lowest way wins
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit      = p_strobe && !bypass && (|match);
    assign hit_data = way_data[hit_way];

    ////////////////////////////////////////
    // victim choice
    ////////////////////////////////////////
    always_comb begin
        any_invalid = 1'b0;
        invalid_way = '0;
        for (int w = `DC_WAYS-1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                any_invalid = 1'b1;
                invalid_way = way_t'(w);
            end
        end
    end

    // strict compare keeps the lowest index on equal ages
    always_comb begin
        oldest_way = '0;
        oldest_age = way_age[0];
        for (int w = 1; w < `DC_WAYS; w++) begin
            if (way_age[w] > oldest_age) begin
                oldest_way = way_t'(w);
                oldest_age = way_age[w];
            end
        end
    end

    assign victim_way   = any_invalid ? invalid_way : oldest_way;
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];
    assign victim_data  = way_data[victim_way];   // write-back payload

endmodule

//--- design/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

    // address and data
    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_WORD_W/8-1:0] byte_en_t;   // one bit per byte lane

    // address fields
    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_SET_BITS-1:0] index_t;

    // way bookkeeping
    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;
    typedef logic [`DC_AGE_W-1:0]        age_t;

    ////////////////////////////////////////
    // miss handling FSM
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        ms_idle,        // lookup, hits and bypass traffic
        ms_write_back,  // dirty victim to memory
        ms_refill       // requested word from memory
    } miss_state_t;

endpackage

//--- design/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

////////////////////////////////////////
// address and data geometry
////////////////////////////////////////
`define DC_ADDR_W        32
`define DC_WORD_W        32
`define DC_OFFSET_BITS   2     // byte offset inside a word
`define DC_SET_BITS      7
`define DC_SETS          (1 << `DC_SET_BITS)
`define DC_TAG_W         (`DC_ADDR_W - `DC_SET_BITS - `DC_OFFSET_BITS)

// organisation
`define DC_WAYS          4
`define DC_AGE_W         4     // saturating age counter

// uncached window, top address bits
`define DC_UNCACHED_W    3
`define DC_UNCACHED_CODE 3'b101

`endif
